//--- Bender.yml
package:
  name: vendingMachine

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/vendTypesPkg.sv
      - design/displayTypesPkg.sv
      - design/keyDebouncer.sv
      - design/vendController.sv
      - design/ledBlinker.sv
      - design/displayDriver.sv
      - design/vendingMachine.sv
  - target: simulation
    include_dirs:
      - include
      - verif
    files:
      - verif/vendingMachineTb.sv

//--- design/displayDriver.sv
`default_nettype none

module displayDriver import vendTypesPkg::*, displayTypesPkg::*; (
	input vendStatusT status,
	input logic countView,
	output segmentT hex0,
	output segmentT hex1,
	output segmentT hex2,
	output segmentT hex3
);

	localparam segmentT SegBlank = 7'b1111111;
	localparam segmentT SegE = 7'b0000110;
	localparam segmentT SegR = 7'b0101111;

	dispModeT mode;
	logic [11:0] bcd;
	digitT hundreds;
	digitT tens;
	digitT units;

	// shift-add-3 over the eight credit bits
	function automatic logic [11:0] toBcd(input centsT value);
		logic [19:0] shiftReg;
		shiftReg = {12'b0, value};
		for (int i = 0; i < 8; i++) begin
			if (shiftReg[11:8] > 4'd4) begin
				shiftReg[11:8] = shiftReg[11:8] + 4'd3;
			end
			if (shiftReg[15:12] > 4'd4) begin
				shiftReg[15:12] = shiftReg[15:12] + 4'd3;
			end
			if (shiftReg[19:16] > 4'd4) begin
				shiftReg[19:16] = shiftReg[19:16] + 4'd3;
			end
			shiftReg = shiftReg << 1;
		end
		return shiftReg[19:8];
	endfunction

	function automatic segmentT encodeDigit(input digitT digit);
		case (digit)
			4'h0: return 7'b1000000;
			4'h1: return 7'b1111001;
			4'h2: return 7'b0100100;
			4'h3: return 7'b0110000;
			4'h4: return 7'b0011001;
			4'h5: return 7'b0010010;
			4'h6: return 7'b0000010;
			4'h7: return 7'b1111000;
			4'h8: return 7'b0000000;
			4'h9: return 7'b0010000;
			4'hA: return 7'b0001000;
			4'hB: return 7'b0000011;
			4'hC: return 7'b1000110;
			4'hD: return 7'b0100001;
			4'hE: return 7'b0000110;
			4'hF: return 7'b0001110;
			default: return SegBlank;
		endcase
	endfunction

	assign bcd = toBcd(status.credit);
	assign hundreds = bcd[11:8];
	assign tens = bcd[7:4];
	assign units = bcd[3:0];

	// error wins over the count view
	always_comb begin
		if (status.state == error) begin
			mode = modeError;
		end else if (countView) begin
			mode = modeCount;
		end else begin
			mode = modeCredit;
		end
	end

	always_comb begin
		hex3 = SegBlank;
		hex2 = SegBlank;
		hex1 = SegBlank;
		hex0 = SegBlank;
		case (mode)
			modeError: begin
				hex2 = SegE;
				hex1 = SegR;
				hex0 = SegR;
			end
			modeCount: begin
				hex0 = encodeDigit(status.count);
			end
			default: begin
				hex2 = encodeDigit(hundreds);
				hex1 = encodeDigit(tens);
				hex0 = encodeDigit(units);
			end
		endcase
	end

endmodule

`default_nettype wire

//--- design/displayTypesPkg.sv
`default_nettype none

package displayTypesPkg;

	// active-low segments, bit 6 is g and bit 0 is a
	typedef logic [6:0] segmentT;

	// one decimal or hex digit
	typedef logic [3:0] digitT;

	// red LED bar
	typedef logic [9:0] ledBarT;

	// what the four digits show
	typedef enum logic [1:0] {
		modeCredit,
		modeCount,
		modeError
	} dispModeT;

endpackage

`default_nettype wire

//--- design/keyDebouncer.sv
`default_nettype none

`include "vending_params.svh"

module keyDebouncer (
	input logic clock,
	input logic rst,
	input logic key,
	output logic press
);

	localparam int CntW = $clog2(`DEBOUNCE_TICKS);

	logic keyMeta;
	logic keySync;
	logic keyLevel;
	logic [CntW-1:0] stableCnt;

	always_ff @(posedge clock) begin
		if (rst) begin
			keyMeta <= 1'b1;
			keySync <= 1'b1;
			keyLevel <= 1'b1;
			stableCnt <= '0;
			press <= 1'b0;
		end else begin
			keyMeta <= key;
			keySync <= keyMeta;
			press <= 1'b0;
			// any bounce back to the accepted level restarts the count
			if (keySync == keyLevel) begin
				stableCnt <= '0;
			end else if (stableCnt == CntW'(`DEBOUNCE_TICKS - 1)) begin
				stableCnt <= '0;
				keyLevel <= keySync;
				// key is active low, so a falling level is the press
				press <= ~keySync;
			end else begin
				stableCnt <= stableCnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- design/ledBlinker.sv
`default_nettype none

`include "vending_params.svh"

module ledBlinker import vendTypesPkg::*, displayTypesPkg::*; (
	input logic clock,
	input logic rst,
	input vendStatusT status,
	output ledBarT ledr
);

	localparam int PeriodW = $clog2(`BLINK_CYCLES);

	logic [PeriodW-1:0] periodCnt;
	logic phase;

	always_ff @(posedge clock) begin
		if (rst || status.state != vending) begin
			periodCnt <= '0;
			phase <= 1'b0;
		end else begin
			// toggles on the first vend cycle, so the bar starts lit
			if (periodCnt == '0) begin
				phase <= ~phase;
			end
			if (periodCnt == PeriodW'(`BLINK_CYCLES - 1)) begin
				periodCnt <= '0;
			end else begin
				periodCnt <= periodCnt + 1'b1;
			end
		end
	end

	assign ledr = {10{phase}};

endmodule

`default_nettype wire

//--- design/vendController.sv
`default_nettype none

`include "vending_params.svh"

module vendController import vendTypesPkg::*; (
	input logic clock,
	input logic rst,
	input logic press,
	input switchT sw,
	output vendStatusT status
);

	localparam int TimerW = $clog2(`VEND_CYCLES);
	localparam centsT Price = centsT'(`PRICE_CENTS);

	logic [4:0] selBits;
	logic conflict;
	logic coinSet;
	centsT coinValue;
	logic [8:0] creditSum;
	centsT addedCredit;
	logic [TimerW-1:0] vendTimer;
	logic timerDone;
	vendStatusT nextStatus;

	// refund plus the four coins
	assign selBits = {sw[8], sw[3:0]};
	assign conflict = $countones(selBits) > 1;
	assign coinSet = |sw[3:0];

	always_comb begin
		coinValue = '0;
		if (sw[0]) begin
			coinValue = centsT'(`NICKEL_CENTS);
		end else if (sw[1]) begin
			coinValue = centsT'(`DIME_CENTS);
		end else if (sw[2]) begin
			coinValue = centsT'(`QUARTER_CENTS);
		end else if (sw[3]) begin
			coinValue = centsT'(`DOLLAR_CENTS);
		end
	end

	// saturate at 255 cents
	assign creditSum = {1'b0, status.credit} + {1'b0, coinValue};
	assign addedCredit = creditSum[8] ? '1 : creditSum[7:0];

	assign timerDone = vendTimer == TimerW'(`VEND_CYCLES - 1);

	always_comb begin
		nextStatus = status;
		case (status.state)
			idle: begin
				if (press) begin
					if (conflict) begin
						nextStatus.state = error;
						nextStatus.credit = '0;
					end else if (sw[8]) begin
						nextStatus.credit = '0;
					end else if (coinSet) begin
						if (addedCredit >= Price) begin
							nextStatus.state = vending;
							nextStatus.credit = addedCredit - Price;
							nextStatus.count = status.count + countT'(1);
						end else begin
							nextStatus.credit = addedCredit;
						end
					end
				end
			end
			vending: begin
				// presses are dropped until the vend ends
				if (timerDone) begin
					nextStatus.state = idle;
				end
			end
			error: begin
				if (press) begin
					nextStatus.state = idle;
				end
			end
			default: begin
				nextStatus.state = idle;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			status <= '{state: idle, credit: '0, count: '0};
		end else begin
			status <= nextStatus;
		end
	end

	// held at zero outside a vend so each vend starts from the top
	always_ff @(posedge clock) begin
		if (rst || status.state != vending) begin
			vendTimer <= '0;
		end else begin
			vendTimer <= vendTimer + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- design/vendTypesPkg.sv
`default_nettype none

package vendTypesPkg;

	// credit in cents, saturates at 255
	typedef logic [7:0] centsT;

	// dispensed items, wraps at 16
	typedef logic [3:0] countT;

	// slide switches
	// 0 nickel, 1 dime, 2 quarter, 3 dollar, 8 refund, 9 count view
	typedef logic [9:0] switchT;

	typedef enum logic [1:0] {
		idle,
		vending,
		error
	} vendStateT;

	typedef struct packed {
		vendStateT state;
		centsT credit;
		countT count;
	} vendStatusT;

endpackage

`default_nettype wire

//--- design/vendingMachine.sv
`default_nettype none

module vendingMachine import vendTypesPkg::*, displayTypesPkg::*; (
	input logic clock,
	input logic rst,
	input switchT sw,
	input logic key,
	output ledBarT ledr,
	output segmentT hex0,
	output segmentT hex1,
	output segmentT hex2,
	output segmentT hex3
);

	logic press;
	vendStatusT status;

	keyDebouncer debouncer (
		.clock(clock),
		.rst(rst),
		.key(key),
		.press(press)
	);

	vendController controller (
		.clock(clock),
		.rst(rst),
		.press(press),
		.sw(sw),
		.status(status)
	);

	ledBlinker blinker (
		.clock(clock),
		.rst(rst),
		.status(status),
		.ledr(ledr)
	);

	// switch 9 picks the count view
	displayDriver display (
		.status(status),
		.countView(sw[9]),
		.hex0(hex0),
		.hex1(hex1),
		.hex2(hex2),
		.hex3(hex3)
	);

endmodule

`default_nettype wire

//--- include/vending_params.svh
`ifndef VENDING_PARAMS_SVH
`define VENDING_PARAMS_SVH

// item price in cents
`define PRICE_CENTS 35

// coin values in cents
`define NICKEL_CENTS 5
`define DIME_CENTS 10
`define QUARTER_CENTS 25
`define DOLLAR_CENTS 100

// stable cycles before a key level is taken
`define DEBOUNCE_TICKS 20

// length of one vend
`define VEND_CYCLES 64

// half period of the LED blink
`define BLINK_CYCLES 8

`endif

//--- vendingMachine.f
+incdir+include
+incdir+verif
design/vendTypesPkg.sv
design/displayTypesPkg.sv
design/keyDebouncer.sv
design/vendController.sv
design/ledBlinker.sv
design/displayDriver.sv
design/vendingMachine.sv
verif/vendingMachineTb.sv

//--- verif/vendModel.svh
`ifndef VEND_MODEL_SVH
`define VEND_MODEL_SVH

// codes for decoded glyphs that are not hex digits
localparam int BlankGlyph = 'h10;
localparam int RGlyph = 'h11;
localparam int UnknownGlyph = 'hFF;

// next status after one press, following the controller rules
function automatic vendStatusT vendModel(input vendStatusT cur, input switchT sel);
	vendStatusT nxt;
	int picked;
	int cents;
	nxt = cur;
	picked = int'(sel[0]) + int'(sel[1]) + int'(sel[2]) + int'(sel[3]) + int'(sel[8]);
	cents = cur.credit;
	if (cur.state == error) begin
		nxt.state = idle;
	end else if (cur.state == idle) begin
		if (picked > 1) begin
			nxt.state = error;
			nxt.credit = '0;
		end else if (sel[8]) begin
			nxt.credit = '0;
		end else if (picked == 1) begin
			if (sel[0]) cents += `NICKEL_CENTS;
			if (sel[1]) cents += `DIME_CENTS;
			if (sel[2]) cents += `QUARTER_CENTS;
			if (sel[3]) cents += `DOLLAR_CENTS;
			if (cents > 255) cents = 255;
			if (cents >= `PRICE_CENTS) begin
				nxt.state = vending;
				cents -= `PRICE_CENTS;
				// four-bit count wraps after 15
				nxt.count = cur.count + 1'b1;
			end
			nxt.credit = centsT'(cents);
		end
	end
	return nxt;
endfunction

// active-low segments back to a digit, bit 0 is segment a
function automatic int decodeSegment(input segmentT seg);
	case (seg)
		7'b1000000: return 'h0;
		7'b1111001: return 'h1;
		7'b0100100: return 'h2;
		7'b0110000: return 'h3;
		7'b0011001: return 'h4;
		7'b0010010: return 'h5;
		7'b0000010: return 'h6;
		7'b1111000: return 'h7;
		7'b0000000: return 'h8;
		7'b0010000: return 'h9;
		7'b0001000: return 'hA;
		7'b0000011: return 'hB;
		7'b1000110: return 'hC;
		7'b0100001: return 'hD;
		7'b0000110: return 'hE;
		7'b0001110: return 'hF;
		7'b0101111: return RGlyph;
		7'b1111111: return BlankGlyph;
		default: return UnknownGlyph;
	endcase
endfunction

task automatic compareValue(input string name, input logic [31:0] got, input logic [31:0] want);
	checkCount++;
	if (got !== want) begin
		errorCount++;
		$display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, want);
	end
endtask

`endif

//--- verif/vendingMachineTb.sv
`default_nettype none

`include "vending_params.svh"

module vendingMachineTb import vendTypesPkg::*, displayTypesPkg::*; ();

	localparam int PressCycles = `DEBOUNCE_TICKS + 4;
	localparam int NumTests = 6;
	localparam int MaxPresses = 32;
	localparam int Timeout =
		2 * NumTests * (MaxPresses * 2 * PressCycles + `VEND_CYCLES + 20) * 100;
	localparam switchT Nickel = 10'h001;
	localparam switchT Dime = 10'h002;
	localparam switchT Quarter = 10'h004;
	localparam switchT Dollar = 10'h008;
	localparam switchT Refund = 10'h100;

	logic clock = 1'b0;
	logic rst;
	logic key;
	switchT sw;
	ledBarT ledr;
	segmentT hex0, hex1, hex2, hex3;
	vendStatusT expected;
	logic viewOn = 1'b0;
	logic checkPending = 1'b0;
	logic ledWasOn = 1'b0;
	int blinkRises = 0;
	int errorCount = 0;
	int checkCount = 0;
	int testCount = 0;
	int failedTests = 0;
	int testStartErrors = 0;

	`include "vendModel.svh"

	vendingMachine UUT (.*);

	always #50 clock = ~clock;

	initial begin
		#(Timeout);
		$display("watchdog expired before the tests finished");
		$display("TEST FAIL");
		$finish;
	end

	// counts off-to-on steps of the LED bar
	always @(posedge clock) begin
		if (!rst) begin
			if (ledr != '0 && ledr != '1) begin
				$display("ledr lit only part of the bar: %h", ledr);
				errorCount++;
			end
			if (ledr == '1 && !ledWasOn) blinkRises <= blinkRises + 1;
			ledWasOn <= ledr == '1;
		end
	end

	always begin : compareDisplay
		int expDigits[4];
		wait (checkPending);
		expDigits = '{BlankGlyph, BlankGlyph, BlankGlyph, BlankGlyph};
		if (expected.state == error) begin
			expDigits[2] = 'hE;
			expDigits[1] = RGlyph;
			expDigits[0] = RGlyph;
		end else if (sw[9]) begin
			expDigits[0] = expected.count;
		end else begin
			expDigits[2] = expected.credit / 100;
			expDigits[1] = expected.credit / 10 % 10;
			expDigits[0] = expected.credit % 10;
		end
		compareValue("hex0", decodeSegment(hex0), expDigits[0]);
		compareValue("hex1", decodeSegment(hex1), expDigits[1]);
		compareValue("hex2", decodeSegment(hex2), expDigits[2]);
		compareValue("hex3", decodeSegment(hex3), expDigits[3]);
		compareValue("ledr", ledr, 0);
		checkPending = 1'b0;
	end

	task automatic runCheck();
		@(negedge clock);
		checkPending = 1'b1;
		wait (!checkPending);
	endtask

	task automatic applyReset();
		rst <= 1'b1;
		repeat (2) @(posedge clock);
		rst <= 1'b0;
		expected = '{state: idle, credit: '0, count: '0};
	endtask

	task automatic pressKey(input switchT sel);
		@(posedge clock);
		sw <= sel | {viewOn, 9'b0};
		key <= 1'b0;
		repeat (PressCycles) @(posedge clock);
		key <= 1'b1;
		repeat (PressCycles) @(posedge clock);
		sw <= {viewOn, 9'b0};
	endtask

	task automatic applyPress(input switchT sel);
		pressKey(sel);
		expected = vendModel(expected, sel);
		// vend period plus margin
		if (expected.state == vending) begin
			repeat (`VEND_CYCLES + 20) @(posedge clock);
			expected.state = idle;
		end
		runCheck();
	endtask

	task automatic setView(input logic on);
		@(posedge clock);
		viewOn = on;
		sw <= {on, 9'b0};
		runCheck();
	endtask

	task automatic finishTest(input string name);
		testCount++;
		if (errorCount == testStartErrors) begin
			$display("%s: ok", name);
		end else begin
			failedTests++;
			$display("%s: %0d errors", name, errorCount - testStartErrors);
		end
		testStartErrors = errorCount;
	endtask

	initial begin
		switchT coin;
		switchT pair;
		vendStatusT trial;
		int first;
		int second;
		int risesBefore;
		void'($urandom(92));
		rst = 1'b1;
		key = 1'b1;
		sw = '0;
		applyReset();
		runCheck();
		finishTest("reset");

		applyPress(Nickel);
		applyPress(Dime);
		for (int i = 0; i < 4; i++) begin
			coin = Nickel << ($urandom % 3);
			trial = vendModel(expected, coin);
			if (trial.state == idle) applyPress(coin);
		end
		applyPress(Refund);
		finishTest("coin accumulation");

		risesBefore = blinkRises;
		applyPress(Quarter);
		applyPress(Dime);
		if (blinkRises - risesBefore < 2) begin
			$display("ledr did not blink on and off during the vend");
			errorCount++;
		end
		setView(1'b1);
		setView(1'b0);
		applyPress(Dollar);
		finishTest("vending");

		applyPress(Refund);
		applyPress(Nickel);
		applyPress('0);
		applyPress(Refund);
		finishTest("refund and empty press");

		// two distinct picks among the four coins and refund
		first = $urandom % 5;
		second = (first + 1 + $urandom % 4) % 5;
		pair = '0;
		pair[first == 4 ? 8 : first] = 1'b1;
		pair[second == 4 ? 8 : second] = 1'b1;
		applyPress(Nickel);
		applyPress(pair);
		applyPress('0);
		setView(1'b1);
		setView(1'b0);
		finishTest("error");

		@(posedge clock);
		applyReset();
		setView(1'b1);
		repeat (16) begin
			applyPress(Quarter);
			applyPress(Dime);
		end
		finishTest("count wrap");

		$display("tests: %0d, failed: %0d, checks: %0d, errors: %0d",
			testCount, failedTests, checkCount, errorCount);
		if (errorCount == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
